// File: Bender.yml
# Multi-lane word-stream scrambler
package:
  name: lane_xor

dependencies: {}

sources:
  # packages first, then the data path
  - files:
      - source/stream_pkg.sv
      - source/lane_ops_pkg.sv
      - source/tap_delay_line.sv
      - source/lane_pipeline.sv
      - source/xor_combiner.sv
      - source/lane_xor_top.sv

  # bound checks and testbench
  - target: test
    files:
      - verification/lane_xor_sva.sv
      - verification/lane_xor_tb.sv

// File: source/lane_ops_pkg.sv
////////////////////////////////////////////////////////////////////////////
// lane_ops_pkg
// Per-lane scrambling rules: keyed add/subtract, left rotate and
// even-parity fill, plus the full three-step lane transform.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package lane_ops_pkg;

	import stream_pkg::*;

	parameter word_t LANE_KEY_BASE = 32'h0000_1001;
	parameter word_t LANE_KEY_STEP = 32'h0000_0100;
	parameter int unsigned ROT_STEP = 3;

	function automatic word_t lane_key(input int unsigned lane);
		return word_t'(LANE_KEY_BASE + lane * LANE_KEY_STEP);
	endfunction

	function automatic int unsigned lane_rotate(input int unsigned lane);
		return (lane * ROT_STEP + 1) % WORD_WIDTH;
	endfunction

	// odd lanes subtract
	function automatic logic lane_is_sub(input int unsigned lane);
		return lane[0];
	endfunction

	// wraps modulo 2**WORD_WIDTH
	function automatic word_t apply_key(input int unsigned lane, input word_t w);
		return lane_is_sub(lane) ? w - lane_key(lane) : w + lane_key(lane);
	endfunction

	function automatic word_t rotate_left(input word_t w, input int unsigned amt);
		int unsigned sh;
		sh = amt % WORD_WIDTH;
		return (w << sh) | (w >> (WORD_WIDTH - sh)); // sh == 0 leaves w
	endfunction

	function automatic word_t parity_fill(input word_t w);
		word_view_u v;
		v.raw = w;
		v.field.parity = ^v.field.payload; // whole word ends up even
		return v.raw;
	endfunction

	function automatic word_t lane_transform(input int unsigned lane, input word_t w);
		return parity_fill(rotate_left(apply_key(lane, w), lane_rotate(lane)));
	endfunction

endpackage

`default_nettype wire

// File: source/lane_pipeline.sv
////////////////////////////////////////////////////////////////////////////
// lane_pipeline
// Three registered stages for one lane: add or subtract the lane key,
// rotate left by the lane amount, then fill in the even-parity bit.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lane_pipeline #(
	parameter int unsigned LANE_INDEX = 0
) (
	input wire logic clk,
	input wire logic rst,
	input wire stream_pkg::word_t lane_in,
	output stream_pkg::word_t lane_out
);

	import stream_pkg::*;
	import lane_ops_pkg::*;

	localparam int unsigned ROT_AMT = lane_rotate(LANE_INDEX);

	if (LANE_INDEX >= MAX_LANES) begin : g_bad_index
		$fatal(1, "lane_pipeline: LANE_INDEX %0d out of range", LANE_INDEX);
	end

	word_t key_q; // stage 1
	word_t rot_q; // stage 2
	word_view_u par_q; // stage 3, parity in field.parity

	// stage 1 keyed add or subtract
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			key_q <= '0;
		end else begin
			key_q <= apply_key(LANE_INDEX, lane_in);
		end
	end

	// stage 2 fixed rotate, pure wiring
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rot_q <= '0;
		end else begin
			rot_q <= rotate_left(key_q, ROT_AMT);
		end
	end

	// stage 3
	// top bit replaced by the XOR of the 31 payload bits
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			par_q.raw <= '0;
		end else begin
			par_q.raw <= parity_fill(rot_q);
		end
	end

	assign lane_out = par_q.raw;

endmodule

`default_nettype wire

// File: source/lane_xor_top.sv
////////////////////////////////////////////////////////////////////////////
// lane_xor_top
// Multi-lane word scrambler. Delay line feeds LANES lane pipelines,
// whose results are XOR-combined into out. Latency is 5 + k per lane.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lane_xor_top #(
	parameter int unsigned LANES = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire stream_pkg::word_t in,
	output stream_pkg::word_t out
);

	import stream_pkg::*;

	if (LANES < 1 || LANES > MAX_LANES) begin : g_bad_lanes
		$fatal(1, "lane_xor_top: LANES %0d out of range", LANES);
	end

	lane_bus_t taps;
	wire lane_bus_t results; // filled per lane below

	tap_delay_line #(.LANES(LANES)) u_taps (
		.clk (clk),
		.rst (rst),
		.in  (in),
		.taps(taps)
	);

	for (genvar k = 0; k < MAX_LANES; k++) begin : g_lane
		if (k < LANES) begin : g_used
			lane_pipeline #(.LANE_INDEX(k)) u_lane (
				.clk     (clk),
				.rst     (rst),
				.lane_in (taps.lane[k]),
				.lane_out(results.lane[k])
			);
		end else begin : g_unused
			assign results.lane[k] = '0; // tie off
		end
	end

	xor_combiner #(.LANES(LANES)) u_comb (
		.clk  (clk),
		.rst  (rst),
		.lanes(results),
		.out  (out)
	);

endmodule

`default_nettype wire

// File: source/stream_pkg.sv
////////////////////////////////////////////////////////////////////////////
// stream_pkg
// Word and bus types for the multi-lane scrambler data path.
// One word enters per clock; lane buses carry one word per lane.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package stream_pkg;

	parameter int unsigned WORD_WIDTH = 32;
	parameter int unsigned MAX_LANES = 16; // upper bound for LANES

	typedef logic [WORD_WIDTH-1:0] word_t;

	// one word per lane, entry k belongs to lane k
	typedef struct packed {
		word_t [MAX_LANES-1:0] lane;
	} lane_bus_t;

	// even parity sits in the top bit
	typedef struct packed {
		logic parity;
		logic [WORD_WIDTH-2:0] payload;
	} parity_word_t;

	typedef union packed {
		word_t raw;
		parity_word_t field;
	} word_view_u;

endpackage

`default_nettype wire

// File: source/tap_delay_line.sv
////////////////////////////////////////////////////////////////////////////
// tap_delay_line
// History of the most recent LANES input words. The history is
// registered once more onto the tap bus, so lane k gets the word
// from k cycles before lane 0's word.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tap_delay_line #(
	parameter int unsigned LANES = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire stream_pkg::word_t in,
	output stream_pkg::lane_bus_t taps
);

	import stream_pkg::*;

	word_t [LANES-1:0] hist_q; // hist_q[k] is the word from k edges back
	lane_bus_t tap_next;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hist_q <= '0;
		end else begin
			hist_q[0] <= in;
			for (int unsigned k = 1; k < LANES; k++) begin
				hist_q[k] <= hist_q[k-1];
			end
		end
	end

	// lanes beyond LANES stay zero
	always_comb begin
		tap_next = '0;
		for (int unsigned k = 0; k < LANES; k++) begin
			tap_next.lane[k] = hist_q[k];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			taps <= '0;
		end else begin
			taps <= tap_next;
		end
	end

endmodule

`default_nettype wire

// File: source/xor_combiner.sv
////////////////////////////////////////////////////////////////////////////
// xor_combiner
// XOR fold of the first LANES lane results, registered to the output.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module xor_combiner #(
	parameter int unsigned LANES = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire stream_pkg::lane_bus_t lanes,
	output stream_pkg::word_t out
);

	import stream_pkg::*;

	word_t fold;

	always_comb begin
		fold = '0;
		for (int unsigned k = 0; k < MAX_LANES; k++) begin
			if (k < LANES) begin
				fold ^= lanes.lane[k];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out <= '0;
		end else begin
			out <= fold;
		end
	end

endmodule

`default_nettype wire

// File: src.f
source/stream_pkg.sv
source/lane_ops_pkg.sv
source/tap_delay_line.sv
source/lane_pipeline.sv
source/xor_combiner.sv
source/lane_xor_top.sv
verification/lane_xor_sva.sv
verification/lane_xor_tb.sv

// File: verification/lane_xor_sva.sv
////////////////////////////////////////////////////////////////////////////
// lane_xor_sva
// Bound checks on the scrambler output: zero during reset, no unknown
// bits once running, and even parity on every output word.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lane_xor_sva (
	input wire logic clk,
	input wire logic rst,
	input wire stream_pkg::word_t out
);

	import stream_pkg::*;
	import lane_ops_pkg::*;

	int unsigned fail_count = 0; // failures of the checks below

	// async clear, so out is already zero at the next edge
	reset_clears_out: assert property (
		@(posedge clk) rst |-> (out == '0)
	) else begin
		fail_count++;
		$error("out is %h while rst is high", $sampled(out));
	end

	out_known: assert property (
		@(posedge clk) disable iff (rst)
		!$isunknown(out)
	) else begin
		fail_count++;
		$error("out has unknown bits after reset release");
	end

	// every lane word is even, so their XOR is even too
	out_even_parity: assert property (
		@(posedge clk) disable iff (rst)
		(^out) == 1'b0
	) else begin
		fail_count++;
		$error("out %h has odd parity", $sampled(out));
	end

endmodule

bind lane_xor_top lane_xor_sva u_sva (
	.clk(clk),
	.rst(rst),
	.out(out)
);

`default_nettype wire

// File: verification/lane_xor_tb.sv
////////////////////////////////////////////////////////////////////////////
// lane_xor_tb
// Testbench for the multi-lane scrambler. Keeps a history of sampled
// input words and checks out against an XOR-of-lanes reference model
// with a concurrent assertion; drives reset, impulse, random stream and
// mid-stream reset sequences.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lane_xor_tb;

	import stream_pkg::*;
	import lane_ops_pkg::*;

	localparam int unsigned LANES = 4; // DUT default
	localparam int unsigned CLK_PERIOD = 4;
	localparam int unsigned DRIVE_DELAY = 1;
	localparam int unsigned RESET_CYCLES = 10;
	localparam int unsigned PIPE_DELAY = 5; // delay line + 3 stages + combiner
	localparam int unsigned HIST_DEPTH = MAX_LANES + PIPE_DELAY;
	localparam int unsigned SETTLE_EDGES = 4;
	localparam int unsigned WAIT_LIMIT = 40;
	localparam logic [31:0] SEED = 32'h7fce6d77;

	logic clk;
	logic rst;
	word_t in;
	word_t out;

	word_t hist_w [0:HIST_DEPTH-1]; // hist_w[j] sampled j+1 edges back at check time
	word_t expected;
	int unsigned settle_cnt;
	logic armed;
	int unsigned check_errors;
	int unsigned timeout_errors;

	lane_xor_top DUT (
		.clk(clk),
		.rst(rst),
		.in (in),
		.out(out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// key, rotate and parity written out from the lane rules
	function automatic word_t scramble_ref(input int unsigned lane, input word_t w);
		word_t key;
		word_t t;
		logic [2*WORD_WIDTH-1:0] dbl;
		int unsigned amt;
		key = LANE_KEY_BASE + lane * LANE_KEY_STEP;
		if (lane % 2 == 1) begin
			t = w - key;
		end else begin
			t = w + key;
		end
		amt = (lane * ROT_STEP + 1) % WORD_WIDTH;
		dbl = {t, t} << amt;
		t = dbl[2*WORD_WIDTH-1 -: WORD_WIDTH];
		t[WORD_WIDTH-1] = ^t[WORD_WIDTH-2:0];
		return t;
	endfunction

	// out with an all-zero history
	function automatic word_t idle_word();
		word_t acc;
		acc = '0;
		for (int unsigned k = 0; k < LANES; k++) begin
			acc ^= scramble_ref(k, '0);
		end
		return acc;
	endfunction

	// words sampled during reset count as zero
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int j = 0; j < HIST_DEPTH; j++) begin
				hist_w[j] <= '0;
			end
		end else begin
			hist_w[0] <= in;
			for (int j = 1; j < HIST_DEPTH; j++) begin
				hist_w[j] <= hist_w[j-1];
			end
		end
	end

	// pipeline registers clear to zero, not to the transform of zero
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			settle_cnt <= 0;
		end else if (settle_cnt < SETTLE_EDGES) begin
			settle_cnt <= settle_cnt + 1;
		end
	end

	assign armed = (settle_cnt >= SETTLE_EDGES);

	always_comb begin
		expected = '0;
		for (int unsigned k = 0; k < LANES; k++) begin
			expected ^= scramble_ref(k, hist_w[PIPE_DELAY + k]);
		end
	end

	out_matches_model: assert property (
		@(posedge clk) disable iff (rst)
		armed |-> (out == expected)
	) else begin
		check_errors = check_errors + 1;
		$display("ERROR: %0t out expected %h actual %h",
			$time, $sampled(expected), $sampled(out));
	end

	task automatic drive_word(input word_t w);
		@(posedge clk);
		#DRIVE_DELAY;
		in = w;
	endtask

	task automatic run_zeros(input int unsigned n);
		for (int unsigned i = 0; i < n; i++) begin
			drive_word('0);
		end
	endtask

	task automatic run_random(input int unsigned n);
		for (int unsigned i = 0; i < n; i++) begin
			drive_word($urandom);
		end
	endtask

	// waits for out to equal (or leave) the target word
	task automatic wait_out(input word_t target, input logic want_equal, input string what);
		int unsigned cycles;
		logic hit;
		cycles = 0;
		hit = 1'b0;
		while (!hit && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			#DRIVE_DELAY;
			hit = ((out == target) == want_equal);
			cycles++;
		end
		if (!hit) begin
			timeout_errors++;
			$display("timeout at %0t: gave up waiting for %s after %0d cycles",
				$time, what, WAIT_LIMIT);
		end
	endtask

	task automatic pulse_reset(input int unsigned cycles);
		@(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b1;
		in = '0;
		repeat (cycles) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
	endtask

	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		in = '0;
		check_errors = 0;
		timeout_errors = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;

		wait_out(idle_word(), 1'b1, "out to settle to the idle word after reset");
		run_zeros(8);

		// single words between zeros
		drive_word(32'h0000_0001);
		drive_word('0);
		wait_out(idle_word(), 1'b0, "the first impulse to reach out");
		wait_out(idle_word(), 1'b1, "out to return to idle after the first impulse");
		drive_word(32'hdead_beef);
		drive_word('0);
		wait_out(idle_word(), 1'b0, "the second impulse to reach out");
		wait_out(idle_word(), 1'b1, "out to return to idle after the second impulse");

		run_random(300);

		pulse_reset(3); // mid-stream
		run_random(150);
		run_zeros(HIST_DEPTH);
		wait_out(idle_word(), 1'b1, "out to drain back to idle after the random stream");
		run_zeros(4);

		$display("check errors: %0d, timeout errors: %0d, bound assertion errors: %0d",
			check_errors, timeout_errors, DUT.u_sva.fail_count);
		if (check_errors == 0 && timeout_errors == 0 && DUT.u_sva.fail_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
